// ==== fp_format_pkg.sv ====
package fp_format_pkg;

	// IEEE-754 single precision field widths
	localparam int EXP_WIDTH = 8;
	localparam int FRAC_WIDTH = 23;
	localparam int WORD_WIDTH = 1 + EXP_WIDTH + FRAC_WIDTH;

	// Working significand: carry, hidden bit and fraction
	localparam int SIG_WIDTH = FRAC_WIDTH + 2;

	// Aligned operand: hidden bit, fraction, guard, round and sticky
	localparam int ALIGN_WIDTH = SIG_WIDTH + 2;

	// Leading zero count range is 0 to SIG_WIDTH
	localparam int SHIFT_WIDTH = $clog2(SIG_WIDTH + 1);

	// Exponent encodings
	localparam logic [EXP_WIDTH-1:0] EXP_BIAS = 8'd127;
	localparam logic [EXP_WIDTH-1:0] EXP_MAX = 8'd255;

	// Canonical quiet NaN, all NaN results collapse to this
	localparam logic [WORD_WIDTH-1:0] QNAN_WORD = 32'h7FC0_0000;

	// Positive infinity
	// Set bit 31 for the negative one
	localparam logic [WORD_WIDTH-1:0] POS_INF_WORD = 32'h7F80_0000;

	// Field view of a float
	typedef struct packed
	{
		logic sign;
		logic [EXP_WIDTH-1:0] exponent;
		logic [FRAC_WIDTH-1:0] fraction;
	} float_fields_t;

	// Same 32 bits, seen either raw or split into fields
	// Ports move raw words, the stages pick fields apart
	typedef union packed
	{
		logic [WORD_WIDTH-1:0] raw;
		float_fields_t fields;
	} float_word_t;

endpackage

// ==== pipe_ctrl_pkg.sv ====
package pipe_ctrl_pkg;

	// Issue tag width
	localparam int TAG_WIDTH = 4;

	// Lane count used when the top level does not override it
	localparam int DEFAULT_LANES = 4;

	// Issue tag, travels untouched beside the data
	typedef logic [TAG_WIDTH-1:0] tag_t;

	// Operation select
	// Subtract flips the sign of the second operand in alignment
	typedef enum logic
	{
		OP_ADD = 1'b0,
		OP_SUB = 1'b1
	} op_t;

endpackage

// ==== fp_add_align.sv ====
module fp_add_align #(
	parameter int LANES = pipe_ctrl_pkg::DEFAULT_LANES
) (
	input clk,
	input reset,

	// Issue side
	input in_valid,
	input pipe_ctrl_pkg::op_t in_op,
	input pipe_ctrl_pkg::tag_t in_tag,
	input fp_format_pkg::float_word_t [LANES-1:0] in_a,
	input fp_format_pkg::float_word_t [LANES-1:0] in_b,

	// To significand sum stage
	output logic s1_valid,
	output pipe_ctrl_pkg::tag_t s1_tag,
	output logic [LANES-1:0][fp_format_pkg::EXP_WIDTH-1:0] s1_exponent,
	output logic [LANES-1:0] s1_sign,
	output logic [LANES-1:0] s1_subtract,
	output logic [LANES-1:0][fp_format_pkg::ALIGN_WIDTH-1:0] s1_sig_large,
	output logic [LANES-1:0][fp_format_pkg::ALIGN_WIDTH-1:0] s1_sig_small,
	output logic [LANES-1:0] s1_is_inf,
	output logic [LANES-1:0] s1_is_nan
);

	localparam int EW = fp_format_pkg::EXP_WIDTH;
	localparam int FW = fp_format_pkg::FRAC_WIDTH;
	localparam int AW = fp_format_pkg::ALIGN_WIDTH;

	genvar lane;
	generate
		for (lane = 0; lane < LANES; lane++)
		begin : lane_logic
			logic a_sign;
			logic b_sign;
			logic [EW-1:0] a_exp;
			logic [EW-1:0] b_exp;
			logic [FW-1:0] a_frac;
			logic [FW-1:0] b_frac;
			logic a_inf;
			logic a_nan;
			logic b_inf;
			logic b_nan;
			logic a_larger;
			logic sign_large;
			logic [EW-1:0] exp_large;
			logic [EW-1:0] exp_diff;
			logic [FW:0] sig_large;
			logic [FW:0] sig_small;
			logic [4:0] shift;
			logic [AW-1:0] small_ext;
			logic [AW-1:0] small_shifted;
			logic [AW-1:0] small_lost;

			always_comb
			begin
				a_sign = in_a[lane].fields.sign;
				// Subtract is an add with the second sign inverted
				b_sign = in_b[lane].fields.sign ^ (in_op == pipe_ctrl_pkg::OP_SUB);
				a_exp = in_a[lane].fields.exponent;
				b_exp = in_b[lane].fields.exponent;

				// Zero exponent means zero or denormal, both become zero
				a_frac = (a_exp == '0) ? '0 : in_a[lane].fields.fraction;
				b_frac = (b_exp == '0) ? '0 : in_b[lane].fields.fraction;

				a_inf = (a_exp == fp_format_pkg::EXP_MAX) && (a_frac == '0);
				a_nan = (a_exp == fp_format_pkg::EXP_MAX) && (a_frac != '0);
				b_inf = (b_exp == fp_format_pkg::EXP_MAX) && (b_frac == '0);
				b_nan = (b_exp == fp_format_pkg::EXP_MAX) && (b_frac != '0);

				// Magnitude order, exponent then fraction
				a_larger = {a_exp, a_frac} >= {b_exp, b_frac};
				if (a_larger)
				begin
					sign_large = a_sign;
					exp_large = a_exp;
					exp_diff = a_exp - b_exp;
					sig_large = {a_exp != '0, a_frac};
					sig_small = {b_exp != '0, b_frac};
				end
				else
				begin
					sign_large = b_sign;
					exp_large = b_exp;
					exp_diff = b_exp - a_exp;
					sig_large = {b_exp != '0, b_frac};
					sig_small = {a_exp != '0, a_frac};
				end

				// Beyond the operand width everything lands in sticky
				shift = (exp_diff > 8'd27) ? 5'd27 : exp_diff[4:0];
				small_ext = {sig_small, 3'b000};
				small_shifted = small_ext >> shift;
				small_lost = small_ext & ~({AW{1'b1}} << shift);
			end

			always_ff @(posedge clk)
			begin
				s1_exponent[lane] <= exp_large;
				s1_sign[lane] <= sign_large;
				s1_subtract[lane] <= a_sign ^ b_sign;
				s1_sig_large[lane] <= {sig_large, 3'b000};
				// Shifted out bits fold into the sticky position
				s1_sig_small[lane] <= {small_shifted[AW-1:1], small_shifted[0] | (|small_lost)};
				s1_is_inf[lane] <= a_inf | b_inf;
				// Inf minus inf has no answer
				s1_is_nan[lane] <= a_nan | b_nan | (a_inf & b_inf & (a_sign != b_sign));
			end
		end
	endgenerate

	// Occupancy and tag
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			s1_valid <= 1'b0;
			s1_tag <= '0;
		end
		else
		begin
			s1_valid <= in_valid;
			s1_tag <= in_tag;
		end
	end

endmodule

// ==== fp_add_sum.sv ====
module fp_add_sum #(
	parameter int LANES = pipe_ctrl_pkg::DEFAULT_LANES
) (
	input clk,
	input reset,

	// From alignment stage
	input s1_valid,
	input pipe_ctrl_pkg::tag_t s1_tag,
	input [LANES-1:0][fp_format_pkg::EXP_WIDTH-1:0] s1_exponent,
	input [LANES-1:0] s1_sign,
	input [LANES-1:0] s1_subtract,
	input [LANES-1:0][fp_format_pkg::ALIGN_WIDTH-1:0] s1_sig_large,
	input [LANES-1:0][fp_format_pkg::ALIGN_WIDTH-1:0] s1_sig_small,
	input [LANES-1:0] s1_is_inf,
	input [LANES-1:0] s1_is_nan,

	// To normalization detect stage
	output logic s2_valid,
	output pipe_ctrl_pkg::tag_t s2_tag,
	output logic [LANES-1:0][fp_format_pkg::SIG_WIDTH-1:0] s2_sum,
	output logic [LANES-1:0][fp_format_pkg::EXP_WIDTH-1:0] s2_exponent,
	output logic [LANES-1:0] s2_sign,
	output logic [LANES-1:0] s2_subtract,
	output logic [LANES-1:0] s2_round_up,
	output logic [LANES-1:0] s2_is_inf,
	output logic [LANES-1:0] s2_is_nan
);

	localparam int EW = fp_format_pkg::EXP_WIDTH;
	localparam int SW = fp_format_pkg::SIG_WIDTH;
	localparam int AW = fp_format_pkg::ALIGN_WIDTH;

	genvar lane;
	generate
		for (lane = 0; lane < LANES; lane++)
		begin : lane_logic
			logic [AW:0] sum_wide;
			logic [SW-1:0] window;
			logic [EW-1:0] exp_adj;
			logic lsb;
			logic guard;
			logic sticky;

			always_comb
			begin
				// Larger operand is first, so the difference never goes negative
				if (s1_subtract[lane])
					sum_wide = {1'b0, s1_sig_large[lane]} - {1'b0, s1_sig_small[lane]};
				else
					sum_wide = {1'b0, s1_sig_large[lane]} + {1'b0, s1_sig_small[lane]};

				// Place the result LSB at window bit 0 so rounding is a plain increment
				if (sum_wide[AW])
				begin
					// Carry out, one step right
					window = {1'b0, sum_wide[AW:4]};
					exp_adj = s1_exponent[lane] + 1'b1;
					lsb = sum_wide[4];
					guard = sum_wide[3];
					sticky = |sum_wide[2:0];
				end
				else if (sum_wide[AW-1])
				begin
					window = {1'b0, sum_wide[AW-1:3]};
					exp_adj = s1_exponent[lane];
					lsb = sum_wide[3];
					guard = sum_wide[2];
					sticky = |sum_wide[1:0];
				end
				else
				begin
					// Cancellation, one step left
					// Deeper cancellation is exact and finished by the LZ count
					// Zero exponent here only with a zero sum, so the wrap is harmless
					window = {1'b0, sum_wide[AW-2:2]};
					exp_adj = s1_exponent[lane] - 1'b1;
					lsb = sum_wide[2];
					guard = sum_wide[1];
					sticky = sum_wide[0];
				end
			end

			always_ff @(posedge clk)
			begin
				s2_sum[lane] <= window;
				s2_exponent[lane] <= exp_adj;
				s2_sign[lane] <= s1_sign[lane];
				s2_subtract[lane] <= s1_subtract[lane];
				// Nearest even, ties go up only when the LSB is odd
				s2_round_up[lane] <= guard & (sticky | lsb);
				s2_is_inf[lane] <= s1_is_inf[lane];
				s2_is_nan[lane] <= s1_is_nan[lane];
			end
		end
	endgenerate

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			s2_valid <= 1'b0;
			s2_tag <= '0;
		end
		else
		begin
			s2_valid <= s1_valid;
			s2_tag <= s1_tag;
		end
	end

endmodule

// ==== fp_norm_detect.sv ====
module fp_norm_detect #(
	parameter int LANES = pipe_ctrl_pkg::DEFAULT_LANES
) (
	input clk,
	input reset,

	// From significand sum stage
	input s2_valid,
	input pipe_ctrl_pkg::tag_t s2_tag,
	input [LANES-1:0][fp_format_pkg::SIG_WIDTH-1:0] s2_sum,
	input [LANES-1:0][fp_format_pkg::EXP_WIDTH-1:0] s2_exponent,
	input [LANES-1:0] s2_sign,
	input [LANES-1:0] s2_subtract,
	input [LANES-1:0] s2_round_up,
	input [LANES-1:0] s2_is_inf,
	input [LANES-1:0] s2_is_nan,

	// To normalize and pack stage
	output logic s3_valid,
	output pipe_ctrl_pkg::tag_t s3_tag,
	output logic [LANES-1:0][fp_format_pkg::SIG_WIDTH-1:0] s3_significand,
	output logic [LANES-1:0][fp_format_pkg::SHIFT_WIDTH-1:0] s3_norm_shift,
	output logic [LANES-1:0][fp_format_pkg::EXP_WIDTH-1:0] s3_exponent,
	output logic [LANES-1:0] s3_sign,
	output logic [LANES-1:0] s3_is_inf,
	output logic [LANES-1:0] s3_is_nan
);

	localparam int SW = fp_format_pkg::SIG_WIDTH;
	localparam int HW = fp_format_pkg::SHIFT_WIDTH;

	genvar lane;
	generate
		for (lane = 0; lane < LANES; lane++)
		begin : lane_logic
			logic [SW-1:0] rounded;
			logic [HW-1:0] leading_zeroes;

			always_comb
			begin
				// Round first, an overflow into bit 24 then shows up as count 0
				rounded = s2_sum[lane] + SW'(s2_round_up[lane]);

				// Priority encode, highest set bit wins
				// All zero keeps 25
				leading_zeroes = HW'(SW);
				for (int i = 0; i < SW; i++)
				begin
					if (rounded[i])
						leading_zeroes = HW'(SW - 1 - i);
				end
			end

			always_ff @(posedge clk)
			begin
				s3_significand[lane] <= rounded;
				s3_norm_shift[lane] <= leading_zeroes;
				s3_exponent[lane] <= s2_exponent[lane];
				// Exact cancellation gives +0
				s3_sign[lane] <= s2_sign[lane] & ~(s2_subtract[lane] & (rounded == '0));
				s3_is_inf[lane] <= s2_is_inf[lane];
				s3_is_nan[lane] <= s2_is_nan[lane];
			end
		end
	endgenerate

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			s3_valid <= 1'b0;
			s3_tag <= '0;
		end
		else
		begin
			s3_valid <= s2_valid;
			s3_tag <= s2_tag;
		end
	end

endmodule

// ==== fp_normalize_pack.sv ====
module fp_normalize_pack #(
	parameter int LANES = pipe_ctrl_pkg::DEFAULT_LANES
) (
	input clk,
	input reset,

	// From normalization detect stage
	input s3_valid,
	input pipe_ctrl_pkg::tag_t s3_tag,
	input [LANES-1:0][fp_format_pkg::SIG_WIDTH-1:0] s3_significand,
	input [LANES-1:0][fp_format_pkg::SHIFT_WIDTH-1:0] s3_norm_shift,
	input [LANES-1:0][fp_format_pkg::EXP_WIDTH-1:0] s3_exponent,
	input [LANES-1:0] s3_sign,
	input [LANES-1:0] s3_is_inf,
	input [LANES-1:0] s3_is_nan,

	// Result side
	output logic out_valid,
	output pipe_ctrl_pkg::tag_t out_tag,
	output fp_format_pkg::float_word_t [LANES-1:0] out_result
);

	localparam int EW = fp_format_pkg::EXP_WIDTH;
	localparam int FW = fp_format_pkg::FRAC_WIDTH;
	localparam int SW = fp_format_pkg::SIG_WIDTH;
	localparam int HW = fp_format_pkg::SHIFT_WIDTH;

	genvar lane;
	generate
		for (lane = 0; lane < LANES; lane++)
		begin : lane_logic
			logic [SW-1:0] shifted;
			logic signed [EW+1:0] exp_wide;
			fp_format_pkg::float_word_t result;

			always_comb
			begin
				// Leading one ends up in bit 24 and is dropped as the hidden bit
				shifted = s3_significand[lane] << s3_norm_shift[lane];
				// Count 1 is the unshifted case
				exp_wide = $signed({2'b00, s3_exponent[lane]}) + 10'sd1
					- $signed({{(EW + 2 - HW){1'b0}}, s3_norm_shift[lane]});

				result.fields.sign = s3_sign[lane];
				result.fields.exponent = exp_wide[EW-1:0];
				result.fields.fraction = shifted[FW:1];

				if (s3_is_nan[lane])
					result.raw = fp_format_pkg::QNAN_WORD;
				else if (s3_is_inf[lane])
				begin
					result.raw = fp_format_pkg::POS_INF_WORD;
					result.fields.sign = s3_sign[lane];
				end
				else if ((s3_norm_shift[lane] == HW'(SW)) || (exp_wide <= 0))
				begin
					// Zero sum or below the smallest normal
					result.raw = '0;
					result.fields.sign = s3_sign[lane];
				end
				else if (exp_wide >= $signed({2'b00, fp_format_pkg::EXP_MAX}))
				begin
					// Overflow
					result.raw = fp_format_pkg::POS_INF_WORD;
					result.fields.sign = s3_sign[lane];
				end
			end

			always_ff @(posedge clk)
				out_result[lane] <= result;
		end
	endgenerate

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			out_valid <= 1'b0;
			out_tag <= '0;
		end
		else
		begin
			out_valid <= s3_valid;
			out_tag <= s3_tag;
		end
	end

endmodule

// ==== fp_add_pipe.sv ====
module fp_add_pipe #(
	parameter int LANES = pipe_ctrl_pkg::DEFAULT_LANES
) (
	input clk,
	input reset,

	// Issue side, one instruction per cycle
	input in_valid,
	input pipe_ctrl_pkg::op_t in_op,
	input pipe_ctrl_pkg::tag_t in_tag,
	input fp_format_pkg::float_word_t [LANES-1:0] in_a,
	input fp_format_pkg::float_word_t [LANES-1:0] in_b,

	// Result side, four cycles later
	output logic out_valid,
	output pipe_ctrl_pkg::tag_t out_tag,
	output fp_format_pkg::float_word_t [LANES-1:0] out_result
);

	localparam int EW = fp_format_pkg::EXP_WIDTH;
	localparam int SW = fp_format_pkg::SIG_WIDTH;
	localparam int AW = fp_format_pkg::ALIGN_WIDTH;
	localparam int HW = fp_format_pkg::SHIFT_WIDTH;

	// Alignment to sum
	logic s1_valid;
	pipe_ctrl_pkg::tag_t s1_tag;
	logic [LANES-1:0][EW-1:0] s1_exponent;
	logic [LANES-1:0] s1_sign, s1_subtract, s1_is_inf, s1_is_nan;
	logic [LANES-1:0][AW-1:0] s1_sig_large, s1_sig_small;

	// Sum to detect
	logic s2_valid;
	pipe_ctrl_pkg::tag_t s2_tag;
	logic [LANES-1:0][SW-1:0] s2_sum;
	logic [LANES-1:0][EW-1:0] s2_exponent;
	logic [LANES-1:0] s2_sign, s2_subtract, s2_round_up, s2_is_inf, s2_is_nan;

	// Detect to pack
	logic s3_valid;
	pipe_ctrl_pkg::tag_t s3_tag;
	logic [LANES-1:0][SW-1:0] s3_significand;
	logic [LANES-1:0][HW-1:0] s3_norm_shift;
	logic [LANES-1:0][EW-1:0] s3_exponent;
	logic [LANES-1:0] s3_sign, s3_is_inf, s3_is_nan;

	// Stage ports share the wire names above
	fp_add_align #(.LANES(LANES)) u_align (.*);
	fp_add_sum #(.LANES(LANES)) u_sum (.*);
	fp_norm_detect #(.LANES(LANES)) u_norm_detect (.*);
	fp_normalize_pack #(.LANES(LANES)) u_normalize_pack (.*);

endmodule

// ==== tb_fp_add.sv ====
module tb_fp_add;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int LANES = 4;
	localparam int MAX_BATCH = 64;
	localparam int TIMEOUT = 20;
	localparam int LATENCY = 4;

	logic clk = 1'b0;
	logic reset;
	logic in_valid;
	pipe_ctrl_pkg::op_t in_op;
	pipe_ctrl_pkg::tag_t in_tag;
	fp_format_pkg::float_word_t [LANES-1:0] in_a;
	fp_format_pkg::float_word_t [LANES-1:0] in_b;
	logic out_valid;
	pipe_ctrl_pkg::tag_t out_tag;
	fp_format_pkg::float_word_t [LANES-1:0] out_result;

	// Stimulus table for one batch of instructions
	pipe_ctrl_pkg::op_t stim_op [MAX_BATCH];
	pipe_ctrl_pkg::tag_t stim_tag [MAX_BATCH];
	fp_format_pkg::float_word_t [LANES-1:0] stim_a [MAX_BATCH];
	fp_format_pkg::float_word_t [LANES-1:0] stim_b [MAX_BATCH];
	int issue_cycle [MAX_BATCH];

	int cycle = 0;
	int seed = 99;
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int test_errors = 0;
	string test_name = "none";

	fp_add_pipe #(.LANES(LANES)) dut (.*);

	initial
	begin
		forever #20 clk = ~clk;
	end

	// Rising edge count, read only on falling edges
	always @(posedge clk)
		cycle <= cycle + 1;

	// Single to double, zero exponent flushes to signed zero
	function automatic real word_to_real(fp_format_pkg::float_word_t w);
		logic [63:0] bits;
		bits = '0;
		bits[63] = w.fields.sign;
		if (w.fields.exponent == 8'hFF)
		begin
			bits[62:52] = 11'h7FF;
			bits[51:29] = w.fields.fraction;
		end
		else if (w.fields.exponent != 8'h00)
		begin
			// Rebias 127 to 1023
			bits[62:52] = 11'(w.fields.exponent) + 11'd896;
			bits[51:29] = w.fields.fraction;
		end
		return $bitstoreal(bits);
	endfunction

	// Double to single with nearest even, flush to zero and one quiet NaN
	function automatic fp_format_pkg::float_word_t real_to_word(real r);
		logic [63:0] bits;
		logic [24:0] mant;
		int e;
		fp_format_pkg::float_word_t w;
		bits = $realtobits(r);
		w.raw = '0;
		w.fields.sign = bits[63];
		if (bits[62:52] == 11'h7FF)
		begin
			if (bits[51:0] != '0)
				w.raw = 32'h7FC0_0000;
			else
				w.fields.exponent = 8'hFF;
			return w;
		end
		if (bits[62:52] == 11'h000)
			return w;
		e = int'(bits[62:52]) - 896;
		mant = {2'b01, bits[51:29]};
		// Guard is bit 28, the rest is sticky
		if (bits[28] && ((|bits[27:0]) || mant[0]))
			mant = mant + 25'd1;
		if (mant[24])
		begin
			mant = mant >> 1;
			e = e + 1;
		end
		if (e >= 255)
			w.fields.exponent = 8'hFF;
		else if (e > 0)
		begin
			w.fields.exponent = 8'(e);
			w.fields.fraction = mant[22:0];
		end
		return w;
	endfunction

	function automatic fp_format_pkg::float_word_t model_result(pipe_ctrl_pkg::op_t op,
		fp_format_pkg::float_word_t a, fp_format_pkg::float_word_t b);
		// Subtract is an add of the negated second operand
		if (op == pipe_ctrl_pkg::OP_SUB)
			b.fields.sign = ~b.fields.sign;
		return real_to_word(word_to_real(a) + word_to_real(b));
	endfunction

	// Normal operand with exponent 100 to 149, so sums stay normal and finite
	function automatic fp_format_pkg::float_word_t random_normal();
		fp_format_pkg::float_word_t w;
		w.raw = $random(seed);
		w.fields.exponent = 8'(100 + ({$random(seed)} % 50));
		return w;
	endfunction

	task automatic check_word(string what, fp_format_pkg::float_word_t expected,
		fp_format_pkg::float_word_t actual);
		checks++;
		if (actual.raw !== expected.raw)
		begin
			errors++;
			$display("ERR %s %s: expected %08h actual %08h", test_name, what,
				expected.raw, actual.raw);
		end
	endtask

	task automatic check_tag(string what, pipe_ctrl_pkg::tag_t expected,
		pipe_ctrl_pkg::tag_t actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("ERR %s %s: expected %h actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic check_flag(string what, logic expected, logic actual);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("ERR %s %s: expected %b actual %b", test_name, what, expected, actual);
		end
	endtask

	task automatic check_cycle(string what, int expected, int actual);
		checks++;
		if (actual != expected)
		begin
			errors++;
			$display("ERR %s %s: expected %0d actual %0d", test_name, what, expected, actual);
		end
	endtask

	task automatic start_test(string name);
		test_name = name;
		test_errors = errors;
	endtask

	task automatic end_test();
		tests_run++;
		if (errors > test_errors)
		begin
			tests_failed++;
			$display("%s: failed with %0d errors", test_name, errors - test_errors);
		end
		else
			$display("%s: ok", test_name);
	endtask

	task automatic set_instr(int i, pipe_ctrl_pkg::op_t op, pipe_ctrl_pkg::tag_t tag);
		stim_op[i] = op;
		stim_tag[i] = tag;
	endtask

	task automatic set_lane(int i, int lane, logic [31:0] a, logic [31:0] b);
		stim_a[i][lane].raw = a;
		stim_b[i][lane].raw = b;
	endtask

	// Issues one instruction per falling edge, then idles the input
	task automatic drive_batch(int count);
		for (int i = 0; i < count; i++)
		begin
			@(negedge clk);
			in_valid = 1'b1;
			in_op = stim_op[i];
			in_tag = stim_tag[i];
			in_a = stim_a[i];
			in_b = stim_b[i];
			issue_cycle[i] = cycle;
		end
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	// Results must come back in issue order
	task automatic collect_batch(int count);
		int waited;
		for (int j = 0; j < count; j++)
		begin
			waited = 0;
			do
			begin
				@(negedge clk);
				waited++;
			end
			while (!out_valid && waited < TIMEOUT);
			if (!out_valid)
			begin
				errors++;
				$display("%s: no result before timeout", test_name);
				return;
			end
			check_cycle($sformatf("latency #%0d", j), issue_cycle[j] + LATENCY, cycle);
			check_tag($sformatf("tag #%0d", j), stim_tag[j], out_tag);
			for (int lane = 0; lane < LANES; lane++)
				check_word($sformatf("#%0d lane %0d", j, lane),
					model_result(stim_op[j], stim_a[j][lane], stim_b[j][lane]),
					out_result[lane]);
		end
	endtask

	task automatic run_batch(int count);
		fork
			drive_batch(count);
			collect_batch(count);
		join
	endtask

	task automatic test_reset();
		start_test("reset");
		for (int i = 0; i < 8; i++)
		begin
			@(negedge clk);
			check_flag("out_valid in reset", 1'b0, out_valid);
		end
		reset = 1'b0;
		// Idle pipe must stay empty
		for (int i = 0; i < 6; i++)
		begin
			@(negedge clk);
			check_flag("out_valid idle", 1'b0, out_valid);
		end
		end_test();
	endtask

	task automatic test_basic();
		start_test("basic");
		set_instr(0, pipe_ctrl_pkg::OP_ADD, 4'h3);
		// Equal exponents with carry out
		set_lane(0, 0, 32'h3FC0_0000, 32'h3FA0_0000);
		set_lane(0, 1, 32'h4049_0FDB, 32'h3F80_0000);
		// Cancellation down to 2^-23
		set_lane(0, 2, 32'h3F80_0001, 32'hBF80_0000);
		// Exact zero from a negative first operand
		set_lane(0, 3, 32'hC120_0000, 32'h4120_0000);
		set_instr(1, pipe_ctrl_pkg::OP_ADD, 4'hA);
		// Ties, even stays and odd rounds up
		set_lane(1, 0, 32'h4B80_0000, 32'h3F80_0000);
		set_lane(1, 1, 32'h4B80_0001, 32'h3F80_0000);
		set_lane(1, 2, 32'h3F80_0000, 32'h3380_0000);
		set_lane(1, 3, 32'h3F80_0001, 32'h3380_0000);
		run_batch(2);
		end_test();
	endtask

	task automatic test_stream();
		start_test("stream");
		for (int i = 0; i < 50; i++)
		begin
			set_instr(i, ($random(seed) & 1) ? pipe_ctrl_pkg::OP_SUB : pipe_ctrl_pkg::OP_ADD,
				pipe_ctrl_pkg::tag_t'(i));
			for (int lane = 0; lane < LANES; lane++)
			begin
				stim_a[i][lane] = random_normal();
				stim_b[i][lane] = random_normal();
			end
		end
		run_batch(50);
		end_test();
	endtask

	task automatic test_specials();
		start_test("specials");
		set_instr(0, pipe_ctrl_pkg::OP_ADD, 4'h1);
		set_lane(0, 0, 32'h7F80_0000, 32'h3F80_0000);
		set_lane(0, 1, 32'h7F80_0000, 32'hFF80_0000);
		set_lane(0, 2, 32'h7FC1_2345, 32'h3F80_0000);
		set_lane(0, 3, 32'h7F7F_FFFF, 32'h7F7F_FFFF);
		set_instr(1, pipe_ctrl_pkg::OP_SUB, 4'h2);
		set_lane(1, 0, 32'hFF80_0000, 32'h3F80_0000);
		set_lane(1, 1, 32'hFF7F_FFFF, 32'h7F7F_FFFF);
		set_lane(1, 2, 32'h7F80_0000, 32'h7F80_0000);
		// Signaling NaN also comes out quiet
		set_lane(1, 3, 32'h3F80_0000, 32'h7FA0_0000);
		run_batch(2);
		end_test();
	endtask

	task automatic test_flush();
		start_test("flush");
		set_instr(0, pipe_ctrl_pkg::OP_ADD, 4'h5);
		set_lane(0, 0, 32'h0000_0010, 32'h3F80_0000);
		// Differences of 2^-149 fall below the smallest normal
		set_lane(0, 1, 32'h0080_0001, 32'h8080_0000);
		set_lane(0, 2, 32'h8080_0001, 32'h0080_0000);
		set_lane(0, 3, 32'h807F_FFFF, 32'h0000_0000);
		run_batch(1);
		end_test();
	endtask

	task automatic test_op_select();
		start_test("op_select");
		for (int i = 0; i < 2; i++)
		begin
			set_instr(i, (i == 0) ? pipe_ctrl_pkg::OP_ADD : pipe_ctrl_pkg::OP_SUB,
				pipe_ctrl_pkg::tag_t'(8 + i));
			set_lane(i, 0, 32'h4040_0000, 32'h3F00_0000);
			set_lane(i, 1, 32'hC0A0_0000, 32'h4020_0000);
			set_lane(i, 2, 32'h42C8_0000, 32'h42C6_0000);
			set_lane(i, 3, 32'h3DCC_CCCD, 32'h3E4C_CCCD);
		end
		run_batch(2);
		end_test();
	endtask

	initial
	begin
		reset = 1'b1;
		in_valid = 1'b0;
		in_op = pipe_ctrl_pkg::OP_ADD;
		in_tag = '0;
		in_a = '0;
		in_b = '0;
		test_reset();
		test_basic();
		test_stream();
		test_specials();
		test_flush();
		test_op_select();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== tb.f ====
fp_format_pkg.sv
pipe_ctrl_pkg.sv
fp_add_align.sv
fp_add_sum.sv
fp_norm_detect.sv
fp_normalize_pack.sv
fp_add_pipe.sv
tb_fp_add.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the FP add pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=tb_fp_add_sim

verilator --binary --timing -Wno-fatal --top-module tb_fp_add -f tb.f -o "$SIM"
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator compile failed with status $status"
	exit 1
fi

./obj_dir/"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
	exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
	echo "No result line found in $LOG"
	exit 1
fi
exit 0
